// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -j 0 --top-module mem_subsys_tb -f verilog.f -o mem_subsys_sim
	./obj_dir/mem_subsys_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== data_bus_if.sv ====
`timescale 1ns/10ps

interface data_bus_if import oldland_pkg::*; ();

	word_t addr; // word aligned.
	byte_sel_t bytesel;
	logic wr_en;
	word_t wr_val;
	word_t data;
	logic access; // one cycle strobe.
	logic ack;
	logic error; // only meaningful with ack.

	modport master (
		output addr,
		output bytesel,
		output wr_en,
		output wr_val,
		output access,
		input data,
		input ack,
		input error
	);

	modport slave (
		input addr,
		input bytesel,
		input wr_en,
		input wr_val,
		input access,
		output data,
		output ack,
		output error
	);

endinterface

// ==== data_ram.sv ====
`timescale 1ns/10ps
`include "oldland_cfg.svh"

module data_ram import oldland_pkg::*; (
	input logic clk,
	input logic rst_n,
	data_bus_if.slave bus
);

	localparam int IDX_BITS = $clog2(`MEM_WORDS);

	word_t mem [`MEM_WORDS];
	logic [IDX_BITS-1:0] idx;
	logic in_range;

	assign idx = bus.addr[IDX_BITS+1:2];
	assign in_range = addr_in_range(bus.addr);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake, ack one cycle after the strobe.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bus.ack <= 1'b0;
			bus.error <= 1'b0;
		end else begin
			bus.ack <= bus.access;
			bus.error <= bus.access & ~in_range;
		end
	end

	// array and read word.
	always_ff @(posedge clk) begin
		if (bus.access) begin
			bus.data <= in_range ? mem[idx] : '0; // zero on a range error.
			if (bus.wr_en && in_range) begin
				for (int i = 0; i < 4; i++) begin
					if (bus.bytesel[i])
						mem[idx][i*8 +: 8] <= bus.wr_val[i*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== debug_access_regs.sv ====
`timescale 1ns/10ps
`include "oldland_cfg.svh"

module debug_access_regs import oldland_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic host_wr,
	input host_sel_t host_sel,
	input word_t host_wdata,
	output word_t host_rdata,
	debug_port_if.ctrl dbg
);

	dbg_state_t state;
	word_t addr_reg;
	word_t wdata_reg;
	word_t rdata_reg;
	logic en_reg;
	logic wr_reg;
	mem_width_t width_reg;
	logic issue;
	logic err_reg;
	logic host_ok;
	logic go_wr;

	// registers are frozen while an access is outstanding.
	assign host_ok = host_wr && (state == DBG_IDLE);
	assign go_wr = host_ok && (host_sel == `DBG_REG_CTRL) &&
		host_wdata[`CTRL_GO] && host_wdata[`CTRL_DBG_EN];

	always_ff @(posedge clk) begin
		if (host_ok && host_sel == `DBG_REG_ADDR)
			addr_reg <= host_wdata;
		if (host_ok && host_sel == `DBG_REG_WDATA)
			wdata_reg <= host_wdata;
		if (dbg.compl)
			rdata_reg <= dbg.rd_val;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			en_reg <= 1'b0;
			wr_reg <= 1'b0;
			width_reg <= `WIDTH_WORD;
		end else if (host_ok && host_sel == `DBG_REG_CTRL) begin
			en_reg <= host_wdata[`CTRL_DBG_EN];
			wr_reg <= host_wdata[`CTRL_WRITE];
			width_reg <= host_wdata[`CTRL_WIDTH_MSB:`CTRL_WIDTH_LSB];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// access FSM.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= DBG_IDLE;
			issue <= 1'b0;
			err_reg <= 1'b0;
		end else begin
			issue <= go_wr; // strobe lands the cycle after go.
			case (state)
			DBG_IDLE: begin
				if (go_wr) begin
					state <= DBG_BUSY;
					err_reg <= 1'b0;
				end
			end
			DBG_BUSY: begin
				if (dbg.compl) begin
					state <= DBG_IDLE;
					err_reg <= ~addr_in_range(addr_reg);
				end
			end
			endcase
		end
	end

	assign dbg.en = en_reg;
	assign dbg.access = issue;
	assign dbg.wr_en = wr_reg;
	assign dbg.addr = addr_reg;
	assign dbg.width = width_reg;
	assign dbg.wr_val = wdata_reg;

	always_comb begin
		host_rdata = '0;
		case (host_sel)
		`DBG_REG_ADDR: host_rdata = addr_reg;
		`DBG_REG_WDATA: host_rdata = wdata_reg;
		`DBG_REG_CTRL: begin
			host_rdata[`STAT_BUSY] = (state == DBG_BUSY);
			host_rdata[`STAT_ERROR] = err_reg;
		end
		`DBG_REG_RDATA: host_rdata = rdata_reg;
		endcase
	end

endmodule

// ==== debug_port_if.sv ====
`timescale 1ns/10ps

interface debug_port_if import oldland_pkg::*; ();

	logic en; // debug owns the bus.
	logic access;
	logic wr_en;
	word_t addr;
	mem_width_t width;
	word_t wr_val;
	word_t rd_val;
	logic compl;

	modport ctrl (
		output en,
		output access,
		output wr_en,
		output addr,
		output width,
		output wr_val,
		input rd_val,
		input compl
	);

	modport mem (
		input en,
		input access,
		input wr_en,
		input addr,
		input width,
		input wr_val,
		output rd_val,
		output compl
	);

endinterface

// ==== mem_subsys_checker.sv ====
`timescale 1ns/10ps
`include "oldland_cfg.svh"

module mem_subsys_checker import oldland_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic store,
	input logic mem_wr_en,
	input word_t addr,
	input word_t mdr,
	input word_t wr_val,
	input mem_width_t width,
	input logic update_rd,
	input reg_sel_t rd_sel,
	input word_t reg_wr_val,
	input logic update_rd_out,
	input reg_sel_t rd_sel_out,
	input logic complete,
	input logic fault,
	input logic host_wr,
	input host_sel_t host_sel,
	input word_t host_wdata,
	input word_t host_rdata,
	input logic host_rd,
	input logic exp_valid,
	input word_t exp_val,
	input string test_name,
	output int error_count,
	output int check_count
);

	localparam int AW = $clog2(4 * `MEM_WORDS);

	logic [7:0] model [4 * `MEM_WORDS]; // byte image of the ram.
	logic pend_valid;
	logic pend_wb;
	logic pend_err;
	logic pend_dbg;
	reg_sel_t pend_rd;
	word_t pend_val;
	logic byp_upd;
	reg_sel_t byp_rd;
	word_t byp_val;
	logic dbg_en;
	logic dbg_wr;
	logic dbg_busy;
	logic dbg_err;
	logic dbg_issue;
	mem_width_t dbg_width;
	word_t dbg_addr;
	word_t dbg_wdata;
	word_t dbg_rdata;
	string prev_name; // entry that issued what completes now.

	task automatic compare(input string name, input string what, input word_t exp,
		input word_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Fail %s %s: expected %h, actual %h", name, what, exp, act);
		end
	endtask

	// read old contents, then write the addressed lanes.
	task automatic mem_access(input word_t a, input mem_width_t w, input logic wr,
		input word_t d, output word_t rd);
		int n;
		logic [AW-1:0] b;
		rd = '0;
		if (a >= word_t'(4 * `MEM_WORDS))
			return;
		n = (w == `WIDTH_BYTE) ? 1 : ((w == `WIDTH_HALF) ? 2 : 4);
		b = a[AW-1:0] & ~AW'(n - 1);
		for (int i = 0; i < n; i++) begin
			rd[i*8 +: 8] = model[b + AW'(i)];
			if (wr)
				model[b + AW'(i)] = d[i*8 +: 8];
		end
	endtask

	task automatic start_access(input word_t a, input mem_width_t w, input logic wr,
		input word_t d, input logic wb, input logic from_dbg);
		pend_valid = 1'b1;
		pend_err = (a >= word_t'(4 * `MEM_WORDS));
		pend_wb = wb;
		pend_dbg = from_dbg;
		pend_rd = rd_sel;
		mem_access(a, w, wr, d, pend_val);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per cycle compare, then advance the model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge clk) begin : watch
		logic exp_upd;
		logic host_ok;
		word_t exp_host;
		if (!rst_n) begin
			pend_valid = 1'b0;
			byp_upd = 1'b0;
			dbg_en = 1'b0;
			dbg_wr = 1'b0;
			dbg_busy = 1'b0;
			dbg_err = 1'b0;
			dbg_issue = 1'b0;
			dbg_width = `WIDTH_WORD;
			prev_name = test_name;
		end else begin
			exp_upd = pend_valid ? pend_wb : byp_upd;
			compare(prev_name, "complete", word_t'(pend_valid), word_t'(complete));
			compare(prev_name, "fault", word_t'(pend_valid & pend_err), word_t'(fault));
			compare(prev_name, "update_rd_out", word_t'(exp_upd), word_t'(update_rd_out));
			if (exp_upd) begin
				compare(prev_name, "rd_sel_out", word_t'(pend_valid ? pend_rd : byp_rd),
					word_t'(rd_sel_out));
				compare(prev_name, "reg_wr_val", pend_valid ? pend_val : byp_val,
					reg_wr_val);
			end
			if (host_rd) begin
				case (host_sel)
				`DBG_REG_ADDR: exp_host = dbg_addr;
				`DBG_REG_WDATA: exp_host = dbg_wdata;
				`DBG_REG_CTRL: exp_host = {30'd0, dbg_err, dbg_busy};
				default: exp_host = dbg_rdata;
				endcase
				compare(test_name, "host_rdata", exp_host, host_rdata);
				if (exp_valid)
					compare(test_name, "host_rdata table", exp_val, host_rdata);
			end
			host_ok = host_wr && !dbg_busy; // busy through the completion cycle.
			if (pend_valid && pend_dbg) begin
				dbg_busy = 1'b0;
				dbg_err = pend_err;
				dbg_rdata = pend_val;
			end
			pend_valid = 1'b0;
			if (dbg_issue)
				start_access(dbg_addr, dbg_width, dbg_wr, dbg_wdata, 1'b0, 1'b1);
			else if (!dbg_en && (load || store))
				start_access(addr, width, mem_wr_en, mdr, load, 1'b0);
			byp_upd = update_rd;
			byp_rd = rd_sel;
			byp_val = wr_val;
			dbg_issue = 1'b0;
			if (host_ok) begin
				case (host_sel)
				`DBG_REG_ADDR: dbg_addr = host_wdata;
				`DBG_REG_WDATA: dbg_wdata = host_wdata;
				`DBG_REG_CTRL: begin
					dbg_en = host_wdata[`CTRL_DBG_EN];
					dbg_wr = host_wdata[`CTRL_WRITE];
					dbg_width = host_wdata[`CTRL_WIDTH_MSB:`CTRL_WIDTH_LSB];
					if (host_wdata[`CTRL_GO] && host_wdata[`CTRL_DBG_EN]) begin
						dbg_busy = 1'b1;
						dbg_issue = 1'b1;
						dbg_err = 1'b0;
					end
				end
				default: ;
				endcase
			end
			prev_name = test_name;
		end
	end

endmodule

// ==== mem_subsys_tb.sv ====
`timescale 1ns/10ps
`include "oldland_cfg.svh"

module mem_subsys_tb import oldland_pkg::*; ();

	localparam int K_LOAD = 0;
	localparam int K_STORE = 1;
	localparam int K_BYPASS = 2;
	localparam int K_HOST_WR = 3;
	localparam int K_HOST_RD = 4; // model compare only.
	localparam int K_HOST_CHK = 5; // also against the table value.
	localparam int K_HOST_WAIT = 6; // poll status until idle.
	localparam int MAX_ENTRIES = 48;

	logic clk = 1'b0;
	logic rst_n;
	logic load;
	logic store;
	logic mem_wr_en;
	word_t addr;
	word_t mdr;
	word_t wr_val;
	mem_width_t width;
	logic update_rd;
	reg_sel_t rd_sel;
	word_t reg_wr_val;
	logic update_rd_out;
	reg_sel_t rd_sel_out;
	logic complete;
	logic fault;
	logic host_wr;
	host_sel_t host_sel;
	word_t host_wdata;
	word_t host_rdata;
	logic host_rd;
	logic exp_valid;
	word_t exp_val;
	string test_name;
	int error_count;
	int check_count;

	int t_kind [MAX_ENTRIES];
	word_t t_addr [MAX_ENTRIES]; // byte address or debug register offset.
	mem_width_t t_width [MAX_ENTRIES];
	reg_sel_t t_rd [MAX_ENTRIES];
	word_t t_data [MAX_ENTRIES]; // write data, or expected host read value.
	string t_name [MAX_ENTRIES];
	int n_entries;
	integer seed = 32'h8315_91de;

	oldland_mem_subsys oldland_mem_subsys_inst (.*);
	mem_subsys_checker checker_inst (.*);

	always #4 clk = ~clk;

	task automatic add(input int kind, input word_t a, input mem_width_t w, input reg_sel_t rd,
		input word_t d, input string name);
		t_kind[n_entries] = kind;
		t_addr[n_entries] = a;
		t_width[n_entries] = w;
		t_rd[n_entries] = rd;
		t_data[n_entries] = d;
		t_name[n_entries] = name;
		n_entries++;
	endtask

	task clear_inputs();
		load = 1'b0;
		store = 1'b0;
		mem_wr_en = 1'b0;
		update_rd = 1'b0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		exp_valid = 1'b0;
		addr = '0;
		mdr = '0;
		wr_val = '0;
		width = `WIDTH_WORD;
		rd_sel = '0;
		host_sel = `DBG_REG_ADDR;
		host_wdata = '0;
		exp_val = '0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task build_table();
		add(K_STORE, 32'h100, `WIDTH_WORD, 3'd0, $random(seed), "word_store");
		add(K_LOAD, 32'h100, `WIDTH_WORD, 3'd1, 32'h0, "word_load");
		add(K_STORE, 32'h200, `WIDTH_WORD, 3'd0, $random(seed), "lane_init");
		add(K_STORE, 32'h200, `WIDTH_BYTE, 3'd0, $random(seed), "byte_lane0");
		add(K_STORE, 32'h203, `WIDTH_BYTE, 3'd0, $random(seed), "byte_lane3");
		add(K_STORE, 32'h204, `WIDTH_WORD, 3'd0, $random(seed), "half_init");
		add(K_STORE, 32'h206, `WIDTH_HALF, 3'd0, $random(seed), "half_lane2");
		add(K_STORE, 32'h208, `WIDTH_WORD, 3'd0, $random(seed), "mix_init");
		add(K_STORE, 32'h209, `WIDTH_BYTE, 3'd0, $random(seed), "byte_lane1");
		add(K_STORE, 32'h20a, `WIDTH_BYTE, 3'd0, $random(seed), "byte_lane2");
		add(K_STORE, 32'h208, `WIDTH_HALF, 3'd0, $random(seed), "half_lane0");
		add(K_LOAD, 32'h200, `WIDTH_WORD, 3'd2, 32'h0, "byte_merge");
		add(K_LOAD, 32'h204, `WIDTH_WORD, 3'd3, 32'h0, "half_merge");
		add(K_LOAD, 32'h208, `WIDTH_WORD, 3'd4, 32'h0, "mix_merge");
		add(K_LOAD, 32'h203, `WIDTH_BYTE, 3'd5, 32'h0, "byte_load3");
		add(K_LOAD, 32'h209, `WIDTH_BYTE, 3'd6, 32'h0, "byte_load1");
		add(K_LOAD, 32'h206, `WIDTH_HALF, 3'd7, 32'h0, "half_load2");
		add(K_LOAD, 32'h208, `WIDTH_HALF, 3'd1, 32'h0, "half_load0");
		add(K_BYPASS, 32'h0, `WIDTH_WORD, 3'd5, $random(seed), "bypass_a");
		add(K_BYPASS, 32'h0, `WIDTH_WORD, 3'd2, $random(seed), "bypass_b");
		add(K_HOST_WR, 32'(`DBG_REG_ADDR), `WIDTH_WORD, 3'd0, 32'h300, "dbg_addr");
		add(K_HOST_WR, 32'(`DBG_REG_WDATA), `WIDTH_WORD, 3'd0, $random(seed), "dbg_wdata");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h1b, "dbg_write_go");
		add(K_HOST_WAIT, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_write_wait");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_release");
		add(K_LOAD, 32'h300, `WIDTH_WORD, 3'd6, 32'h0, "dbg_then_load");
		add(K_HOST_WR, 32'(`DBG_REG_ADDR), `WIDTH_WORD, 3'd0, 32'h100, "dbg_addr_rd");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h19, "dbg_read_go");
		add(K_HOST_WAIT, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_read_wait");
		add(K_HOST_RD, 32'(`DBG_REG_RDATA), `WIDTH_WORD, 3'd0, 32'h0, "dbg_rdata");
		add(K_HOST_CHK, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_status");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_release_rd");
		add(K_STORE, 32'h1100, `WIDTH_WORD, 3'd0, $random(seed), "oor_store");
		add(K_LOAD, 32'h1100, `WIDTH_WORD, 3'd3, 32'h0, "oor_load");
		add(K_LOAD, 32'h100, `WIDTH_WORD, 3'd4, 32'h0, "oor_unchanged");
		add(K_HOST_WR, 32'(`DBG_REG_ADDR), `WIDTH_WORD, 3'd0, 32'h1200, "dbg_oor_addr");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h1b, "dbg_oor_write");
		add(K_HOST_WAIT, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_oor_wait");
		add(K_HOST_CHK, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h2, "dbg_oor_status");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h19, "dbg_oor_read");
		add(K_HOST_WAIT, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_oor_rwait");
		add(K_HOST_RD, 32'(`DBG_REG_RDATA), `WIDTH_WORD, 3'd0, 32'h0, "dbg_oor_rdata");
		add(K_HOST_WR, 32'(`DBG_REG_CTRL), `WIDTH_WORD, 3'd0, 32'h0, "dbg_oor_release");
		add(K_LOAD, 32'h200, `WIDTH_WORD, 3'd7, 32'h0, "dbg_oor_unchanged");
	endtask

	initial begin
		n_entries = 0;
		build_table();
		test_name = "reset";
		clear_inputs();
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clk);
			#1;
			clear_inputs();
			test_name = t_name[i];
			case (t_kind[i])
			K_LOAD, K_STORE: begin
				load = (t_kind[i] == K_LOAD);
				store = (t_kind[i] == K_STORE);
				mem_wr_en = (t_kind[i] == K_STORE);
				addr = t_addr[i];
				width = t_width[i];
				mdr = t_data[i];
				rd_sel = t_rd[i];
			end
			K_BYPASS: begin
				update_rd = 1'b1;
				rd_sel = t_rd[i];
				wr_val = t_data[i];
			end
			K_HOST_WR: begin
				host_wr = 1'b1;
				host_sel = t_addr[i][1:0];
				host_wdata = t_data[i];
			end
			default: begin
				host_rd = 1'b1;
				host_sel = t_addr[i][1:0];
				exp_valid = (t_kind[i] == K_HOST_CHK);
				exp_val = t_data[i];
				if (t_kind[i] == K_HOST_WAIT) begin
					load = 1'b1; // pipeline load while debug owns the bus.
					addr = t_addr[i];
					rd_sel = t_rd[i];
					@(negedge clk);
					while (host_rdata[`STAT_BUSY])
						@(negedge clk);
				end
			end
			endcase
		end
		@(posedge clk);
		#1;
		clear_inputs();
		repeat (2) @(posedge clk); // last completion is checked.
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		#1;
		repeat (n_entries * 6 + 50) @(posedge clk);
		$display("timeout: the test sequence did not finish in the allowed time");
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== oldland_cfg.svh ====
`ifndef OLDLAND_CFG_SVH
`define OLDLAND_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_WORDS 1024 // depth in 32-bit words.

// access width codes, code 3 behaves as a word.
`define WIDTH_BYTE 2'd0
`define WIDTH_HALF 2'd1
`define WIDTH_WORD 2'd2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// debug register map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DBG_REG_ADDR  2'd0
`define DBG_REG_WDATA 2'd1
`define DBG_REG_CTRL  2'd2
`define DBG_REG_RDATA 2'd3

`define CTRL_GO        0
`define CTRL_WRITE     1
`define CTRL_WIDTH_LSB 2
`define CTRL_WIDTH_MSB 3
`define CTRL_DBG_EN    4

// status view at the ctrl offset.
`define STAT_BUSY  0
`define STAT_ERROR 1

`endif

// ==== oldland_mem_subsys.sv ====
`timescale 1ns/10ps

module oldland_mem_subsys import oldland_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic store,
	input logic mem_wr_en,
	input word_t addr,
	input word_t mdr,
	input word_t wr_val,
	input mem_width_t width,
	input logic update_rd,
	input reg_sel_t rd_sel,
	output word_t reg_wr_val,
	output logic update_rd_out,
	output reg_sel_t rd_sel_out,
	output logic complete,
	output logic fault,
	input logic host_wr,
	input host_sel_t host_sel,
	input word_t host_wdata,
	output word_t host_rdata
);

	data_bus_if bus ();
	debug_port_if dbg ();

	oldland_memory oldland_memory_inst (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.store(store),
		.mem_wr_en(mem_wr_en),
		.addr(addr),
		.mdr(mdr),
		.wr_val(wr_val),
		.width(width),
		.update_rd(update_rd),
		.rd_sel(rd_sel),
		.reg_wr_val(reg_wr_val),
		.update_rd_out(update_rd_out),
		.rd_sel_out(rd_sel_out),
		.complete(complete),
		.fault(fault),
		.bus(bus.master),
		.dbg(dbg.mem)
	);

	debug_access_regs debug_access_regs_inst (
		.clk(clk),
		.rst_n(rst_n),
		.host_wr(host_wr),
		.host_sel(host_sel),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.dbg(dbg.ctrl)
	);

	data_ram data_ram_inst (
		.clk(clk),
		.rst_n(rst_n),
		.bus(bus.slave)
	);

endmodule

// ==== oldland_memory.sv ====
`timescale 1ns/10ps
`include "oldland_cfg.svh"

module oldland_memory import oldland_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic store,
	input logic mem_wr_en,
	input word_t addr,
	input word_t mdr,
	input word_t wr_val,
	input mem_width_t width,
	input logic update_rd,
	input reg_sel_t rd_sel,
	output word_t reg_wr_val,
	output logic update_rd_out,
	output reg_sel_t rd_sel_out,
	output logic complete,
	output logic fault,
	data_bus_if.master bus,
	debug_port_if.mem dbg
);

	word_t wr_data;
	word_t rd_shifted;
	word_t mem_rd_val;
	word_t wr_val_bypass;
	reg_sel_t rd_sel_bypass;
	logic update_rd_bypass;
	reg_sel_t mem_rd;
	logic mem_update_rd;
	logic acc_dbg;
	logic [1:0] byte_addr;
	logic [1:0] acc_lane;
	mem_width_t mem_width;
	mem_width_t acc_width;

	// bit offset of the addressed lane.
	function automatic logic [4:0] lane_shift(input mem_width_t w, input logic [1:0] lane);
		case (w)
		`WIDTH_BYTE: return {lane, 3'b000};
		`WIDTH_HALF: return {lane[1], 4'b0000};
		default: return 5'd0;
		endcase
	endfunction

	function automatic byte_sel_t lane_enables(input mem_width_t w, input logic [1:0] lane);
		case (w)
		`WIDTH_BYTE: return 4'b0001 << lane;
		`WIDTH_HALF: return 4'b0011 << {lane[1], 1'b0};
		default: return 4'b1111;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request side, debug overrides the pipeline.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign wr_data = dbg.en ? dbg.wr_val : mdr;
	assign byte_addr = dbg.en ? dbg.addr[1:0] : addr[1:0];
	assign mem_width = dbg.en ? dbg.width : width;

	assign bus.addr = dbg.en ? {dbg.addr[31:2], 2'b00} : {addr[31:2], 2'b00};
	assign bus.wr_en = dbg.en ? dbg.wr_en : mem_wr_en;
	assign bus.access = dbg.en ? dbg.access : (load | store);
	assign bus.bytesel = lane_enables(mem_width, byte_addr);
	assign bus.wr_val = wr_data << lane_shift(mem_width, byte_addr);

	// lane and width of the access in flight.
	always_ff @(posedge clk) begin
		wr_val_bypass <= wr_val;
		rd_sel_bypass <= rd_sel;
		if (bus.access) begin
			mem_rd <= rd_sel;
			acc_lane <= byte_addr;
			acc_width <= mem_width;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			update_rd_bypass <= 1'b0;
			mem_update_rd <= 1'b0;
			acc_dbg <= 1'b0;
		end else begin
			update_rd_bypass <= update_rd;
			if (bus.access) begin
				mem_update_rd <= load & ~dbg.en; // stores and debug never write back.
				acc_dbg <= dbg.en;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read alignment and writeback.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rd_shifted = bus.data >> lane_shift(acc_width, acc_lane);

	always_comb begin
		case (acc_width)
		`WIDTH_BYTE: mem_rd_val = word_t'(rd_shifted[7:0]);
		`WIDTH_HALF: mem_rd_val = word_t'(rd_shifted[15:0]);
		default: mem_rd_val = rd_shifted;
		endcase
	end

	assign complete = bus.ack;
	assign fault = bus.ack & bus.error;

	// completing load wins over the bypass.
	assign reg_wr_val = complete ? mem_rd_val : wr_val_bypass;
	assign update_rd_out = complete ? mem_update_rd : update_rd_bypass;
	assign rd_sel_out = complete ? mem_rd : rd_sel_bypass;

	assign dbg.rd_val = mem_rd_val;
	assign dbg.compl = bus.ack & acc_dbg;

endmodule

// ==== oldland_pkg.sv ====
`include "oldland_cfg.svh"

package oldland_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] word_t;
	typedef logic [3:0] byte_sel_t; // one bit per lane.
	typedef logic [1:0] mem_width_t;
	typedef logic [2:0] reg_sel_t;

	// debug host side.
	typedef logic [1:0] host_sel_t;

	typedef enum logic {
		DBG_IDLE,
		DBG_BUSY
	} dbg_state_t;

	// byte address falls inside the data ram.
	function automatic logic addr_in_range(input word_t a);
		return a < word_t'(4 * `MEM_WORDS);
	endfunction

endpackage

// ==== verilog.f ====
+incdir+.
oldland_pkg.sv
data_bus_if.sv
debug_port_if.sv
oldland_memory.sv
debug_access_regs.sv
data_ram.sv
oldland_mem_subsys.sv
mem_subsys_checker.sv
mem_subsys_tb.sv
